//--- rtl/pmtrdt_pkg.sv
// sizes, opcode enum, uop and result structs, permutation class helper
`default_nettype none

package pmtrdt_pkg;

  // vector geometry, fixed element width
  localparam int num_elem = 8;
  localparam int elem_w = 16;
  localparam int vlen = num_elem * elem_w;
  // element index width, also the compress prefix count width
  localparam int idx_w = $clog2(num_elem);

  // reorder buffer tag
  localparam int tag_w = 4;

  // reservation queue
  localparam int queue_depth = 4;
  localparam int queue_ptr_w = $clog2(queue_depth);
  // one extra bit so a full queue can be told from an empty one
  localparam int queue_cnt_w = queue_ptr_w + 1;

  // register stages in each datapath
  localparam int pipe_stages = 2;

  typedef logic [elem_w-1:0] elem_t;

  // signed extremes, identities for max and min
  localparam elem_t elem_smax = {1'b0, {(elem_w - 1){1'b1}}};
  localparam elem_t elem_smin = {1'b1, {(elem_w - 1){1'b0}}};

  typedef enum logic [3:0] {
    // reductions, max/min signed
    rdt_sum,
    rdt_max,
    rdt_min,
    rdt_and,
    rdt_or,
    rdt_xor,
    // compares, vs2 against vs1
    cmp_eq,
    cmp_lt,
    cmp_ltu,
    // permutations
    pmt_slideup,
    pmt_slidedown,
    pmt_gather,
    pmt_compress
  } pmtrdt_op_e;

  // micro-op as held in the reservation queue
  typedef struct packed {
    pmtrdt_op_e op;
    logic [tag_w-1:0] tag;
    logic [num_elem-1:0] mask;
    logic [vlen-1:0] vs1;
    logic [vlen-1:0] vs2;
  } pmtrdt_uop_t;

  // result towards the reorder buffer
  typedef struct packed {
    logic [tag_w-1:0] tag;
    logic [vlen-1:0] vd;
  } pmtrdt_res_t;

  // true for ops handled by the permutation datapath
  function automatic logic is_pmt(input pmtrdt_op_e op);
    logic hit;
    hit = 1'b0;
    case (op)
      pmt_slideup,
      pmt_slidedown,
      pmt_gather,
      pmt_compress: hit = 1'b1;
      default: hit = 1'b0;
    endcase
    return hit;
  endfunction

endpackage

`default_nettype wire

//--- rtl/pmtrdt_uop_queue.sv
// reservation queue, circular buffer presenting the oldest uop to the lane
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_uop_queue (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    uop_valid,
  input  pmtrdt_pkg::pmtrdt_uop_t uop,
  output logic                    uop_ready,
  output logic                    head_valid,
  output pmtrdt_pkg::pmtrdt_uop_t head,
  input  logic                    advance
);

  // entry storage
  pmtrdt_pkg::pmtrdt_uop_t mem [pmtrdt_pkg::queue_depth];

  logic [pmtrdt_pkg::queue_ptr_w-1:0] wr_ptr;
  logic [pmtrdt_pkg::queue_ptr_w-1:0] rd_ptr;
  logic [pmtrdt_pkg::queue_cnt_w-1:0] count;
  logic push;
  logic pop;

  // full/empty straight from the occupancy count
  assign uop_ready = count != pmtrdt_pkg::queue_cnt_w'(pmtrdt_pkg::queue_depth);
  assign head_valid = count != '0;

  // head read combinationally from the buffer
  assign head = mem[rd_ptr];

  assign push = uop_valid & uop_ready;
  assign pop = head_valid & advance;

  // payload write on push
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= uop;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together keep the count
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/pmtrdt_rdt_cmp.sv
// reduction and compare datapath, two pipeline stages
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_rdt_cmp (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    advance,
  input  logic                    en,
  input  pmtrdt_pkg::pmtrdt_uop_t uop,
  output logic                    out_valid,
  output pmtrdt_pkg::pmtrdt_res_t out
);

  // valid chain, one bit per stage
  logic [pmtrdt_pkg::pipe_stages-1:0] vld;

  // stage 1 payload
  pmtrdt_pkg::pmtrdt_op_e s1_op;
  logic [pmtrdt_pkg::tag_w-1:0] s1_tag;
  pmtrdt_pkg::elem_t s1_scalar;
  pmtrdt_pkg::elem_t [pmtrdt_pkg::num_elem-1:0] s1_elem;
  logic [pmtrdt_pkg::num_elem-1:0] s1_cmp;

  // stage 1 next values
  pmtrdt_pkg::elem_t [pmtrdt_pkg::num_elem-1:0] elem_next;
  logic [pmtrdt_pkg::num_elem-1:0] cmp_next;

  // stage 2 next value
  logic [pmtrdt_pkg::vlen-1:0] vd_next;

  // masking to identity, element-wise compare
  always_comb begin
    pmtrdt_pkg::elem_t a;
    pmtrdt_pkg::elem_t b;
    pmtrdt_pkg::elem_t ident;
    logic hit;
    a = '0;
    b = '0;
    hit = 1'b0;
    case (uop.op)
      pmtrdt_pkg::rdt_and: ident = '1;
      pmtrdt_pkg::rdt_max: ident = pmtrdt_pkg::elem_smin;
      pmtrdt_pkg::rdt_min: ident = pmtrdt_pkg::elem_smax;
      // sum, or, xor
      default: ident = '0;
    endcase
    for (int i = 0; i < pmtrdt_pkg::num_elem; i++) begin
      a = uop.vs2[i*pmtrdt_pkg::elem_w +: pmtrdt_pkg::elem_w];
      b = uop.vs1[i*pmtrdt_pkg::elem_w +: pmtrdt_pkg::elem_w];
      elem_next[i] = uop.mask[i] ? a : ident;
      case (uop.op)
        pmtrdt_pkg::cmp_eq: hit = a == b;
        pmtrdt_pkg::cmp_lt: hit = $signed(a) < $signed(b);
        pmtrdt_pkg::cmp_ltu: hit = a < b;
        default: hit = 1'b0;
      endcase
      // inactive compare bits read 0
      cmp_next[i] = hit & uop.mask[i];
    end
  end

  // fold the elements into the vs1 scalar
  always_comb begin
    pmtrdt_pkg::elem_t acc;
    acc = s1_scalar;
    for (int i = 0; i < pmtrdt_pkg::num_elem; i++) begin
      case (s1_op)
        pmtrdt_pkg::rdt_sum: acc = acc + s1_elem[i];
        pmtrdt_pkg::rdt_max: acc = ($signed(s1_elem[i]) > $signed(acc)) ? s1_elem[i] : acc;
        pmtrdt_pkg::rdt_min: acc = ($signed(s1_elem[i]) < $signed(acc)) ? s1_elem[i] : acc;
        pmtrdt_pkg::rdt_and: acc = acc & s1_elem[i];
        pmtrdt_pkg::rdt_or: acc = acc | s1_elem[i];
        pmtrdt_pkg::rdt_xor: acc = acc ^ s1_elem[i];
        default: acc = acc;
      endcase
    end
    vd_next = '0;
    if (s1_op inside {pmtrdt_pkg::cmp_eq, pmtrdt_pkg::cmp_lt, pmtrdt_pkg::cmp_ltu}) begin
      vd_next[pmtrdt_pkg::num_elem-1:0] = s1_cmp;
    end else begin
      vd_next[pmtrdt_pkg::elem_w-1:0] = acc;
    end
  end

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      vld <= '0;
    end else if (advance) begin
      vld <= {vld[pmtrdt_pkg::pipe_stages-2:0], en};
    end
  end

  // payload moves with the stall signal only
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_op <= uop.op;
      s1_tag <= uop.tag;
      s1_scalar <= uop.vs1[pmtrdt_pkg::elem_w-1:0];
      s1_elem <= elem_next;
      s1_cmp <= cmp_next;
      out.tag <= s1_tag;
      out.vd <= vd_next;
    end
  end

  assign out_valid = vld[pmtrdt_pkg::pipe_stages-1];

endmodule

`default_nettype wire

//--- rtl/pmtrdt_pmt.sv
// permutation datapath for slides, gather and compress, two pipeline stages
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_pmt (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    advance,
  input  logic                    en,
  input  pmtrdt_pkg::pmtrdt_uop_t uop,
  output logic                    out_valid,
  output pmtrdt_pkg::pmtrdt_res_t out
);

  // valid chain, one bit per stage
  logic [pmtrdt_pkg::pipe_stages-1:0] vld;

  // stage 1 payload
  pmtrdt_pkg::pmtrdt_uop_t s1_uop;
  // destination slot of each element under compress
  logic [pmtrdt_pkg::num_elem-1:0][pmtrdt_pkg::idx_w-1:0] s1_pos;

  logic [pmtrdt_pkg::num_elem-1:0][pmtrdt_pkg::idx_w-1:0] pos_next;
  pmtrdt_pkg::elem_t [pmtrdt_pkg::num_elem-1:0] vd_e;

  // exclusive prefix count of the mask
  always_comb begin
    pos_next[0] = '0;
    for (int i = 1; i < pmtrdt_pkg::num_elem; i++) begin
      pos_next[i] = pos_next[i-1] + pmtrdt_pkg::idx_w'(uop.mask[i-1]);
    end
  end

  // element routing
  always_comb begin
    pmtrdt_pkg::elem_t [pmtrdt_pkg::num_elem-1:0] src_e;
    pmtrdt_pkg::elem_t [pmtrdt_pkg::num_elem-1:0] idx_e;
    int off;
    src_e = s1_uop.vs2;
    idx_e = s1_uop.vs1;
    // slide amount from vs1 element 0, full width
    off = int'(idx_e[0]);
    // unwritten elements stay zero
    vd_e = '0;
    case (s1_uop.op)
      pmtrdt_pkg::pmt_slideup: begin
        for (int i = 0; i < pmtrdt_pkg::num_elem; i++) begin
          if (off <= i) begin
            vd_e[i] = src_e[i-off];
          end
        end
      end
      pmtrdt_pkg::pmt_slidedown: begin
        for (int i = 0; i < pmtrdt_pkg::num_elem; i++) begin
          if (i + off < pmtrdt_pkg::num_elem) begin
            vd_e[i] = src_e[i+off];
          end
        end
      end
      pmtrdt_pkg::pmt_gather: begin
        for (int i = 0; i < pmtrdt_pkg::num_elem; i++) begin
          // out of range index reads zero
          if (idx_e[i] < pmtrdt_pkg::elem_w'(pmtrdt_pkg::num_elem)) begin
            vd_e[i] = src_e[idx_e[i][pmtrdt_pkg::idx_w-1:0]];
          end
        end
      end
      pmtrdt_pkg::pmt_compress: begin
        for (int i = 0; i < pmtrdt_pkg::num_elem; i++) begin
          if (s1_uop.mask[i]) begin
            vd_e[s1_pos[i]] = src_e[i];
          end
        end
      end
      default: vd_e = '0;
    endcase
  end

  // control state
  always_ff @(posedge clk) begin
    if (rst) begin
      vld <= '0;
    end else if (advance) begin
      vld <= {vld[pmtrdt_pkg::pipe_stages-2:0], en};
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (advance) begin
      s1_uop <= uop;
      s1_pos <= pos_next;
      out.tag <= s1_uop.tag;
      out.vd <= vd_e;
    end
  end

  assign out_valid = vld[pmtrdt_pkg::pipe_stages-1];

endmodule

`default_nettype wire

//--- rtl/pmtrdt_result_merge.sv
// result merge, output register towards the ROB and the lane advance
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_result_merge (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    rdt_valid,
  input  pmtrdt_pkg::pmtrdt_res_t rdt_res,
  input  logic                    pmt_valid,
  input  pmtrdt_pkg::pmtrdt_res_t pmt_res,
  output logic                    advance,
  output logic                    result_valid,
  output pmtrdt_pkg::pmtrdt_res_t result,
  input  logic                    result_ready
);

  pmtrdt_pkg::pmtrdt_res_t sel_res;
  logic any_valid;

  // only one datapath holds an item per stage
  assign sel_res = pmt_valid ? pmt_res : rdt_res;
  assign any_valid = rdt_valid | pmt_valid;

  // slot free now, or emptied by the ROB this edge
  // stalls the queue and both pipelines together
  assign advance = ~result_valid | result_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_valid <= 1'b0;
    end else if (advance) begin
      // bubble clears the slot
      result_valid <= any_valid;
    end
  end

  // held stable while the ROB back-pressures
  always_ff @(posedge clk) begin
    if (advance && any_valid) begin
      result <= sel_res;
    end
  end

endmodule

`default_nettype wire

//--- rtl/pmtrdt_top.sv
// lane top level, queue, reduction/compare and permutation datapaths, merge
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    uop_valid,
  input  pmtrdt_pkg::pmtrdt_uop_t uop,
  output logic                    uop_ready,
  output logic                    result_valid,
  output pmtrdt_pkg::pmtrdt_res_t result,
  input  logic                    result_ready
);

  logic head_valid;
  pmtrdt_pkg::pmtrdt_uop_t head;
  logic advance;

  // steering by op class
  logic head_is_pmt;
  logic rdt_en;
  logic pmt_en;

  logic rdt_valid;
  pmtrdt_pkg::pmtrdt_res_t rdt_res;
  logic pmt_valid;
  pmtrdt_pkg::pmtrdt_res_t pmt_res;

  assign head_is_pmt = pmtrdt_pkg::is_pmt(head.op);
  assign rdt_en = head_valid & ~head_is_pmt;
  assign pmt_en = head_valid & head_is_pmt;

  pmtrdt_uop_queue u_uop_queue (
    .clk        (clk),
    .rst        (rst),
    .uop_valid  (uop_valid),
    .uop        (uop),
    .uop_ready  (uop_ready),
    .head_valid (head_valid),
    .head       (head),
    .advance    (advance)
  );

  // both datapaths see the head, only one is enabled
  pmtrdt_rdt_cmp u_rdt_cmp (
    .clk       (clk),
    .rst       (rst),
    .advance   (advance),
    .en        (rdt_en),
    .uop       (head),
    .out_valid (rdt_valid),
    .out       (rdt_res)
  );

  pmtrdt_pmt u_pmt (
    .clk       (clk),
    .rst       (rst),
    .advance   (advance),
    .en        (pmt_en),
    .uop       (head),
    .out_valid (pmt_valid),
    .out       (pmt_res)
  );

  pmtrdt_result_merge u_result_merge (
    .clk          (clk),
    .rst          (rst),
    .rdt_valid    (rdt_valid),
    .rdt_res      (rdt_res),
    .pmt_valid    (pmt_valid),
    .pmt_res      (pmt_res),
    .advance      (advance),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

endmodule

`default_nettype wire

//--- dv/pmtrdt_tb.sv
// lane testbench, stimulus table, random ROB back-pressure, in-order checks, watchdog
`timescale 1ns/1ps
`default_nettype none

module pmtrdt_tb;

  localparam int num_tests = 18;
  localparam int clk_half = 20;
  localparam int reset_cycles = 16;
  // 40 cycles per table entry on top of reset
  localparam int timeout_cycles = num_tests * 40 + reset_cycles;
  localparam int seed = 42;
  localparam int res_w = pmtrdt_pkg::vlen + pmtrdt_pkg::tag_w;

  logic clk;
  logic rst;
  logic uop_valid;
  pmtrdt_pkg::pmtrdt_uop_t uop;
  logic uop_ready;
  logic result_valid;
  pmtrdt_pkg::pmtrdt_res_t result;
  logic result_ready;

  // stimulus table whose index doubles as the tag
  string test_name [num_tests];
  pmtrdt_pkg::pmtrdt_uop_t test_uop [num_tests];
  logic [pmtrdt_pkg::vlen-1:0] test_vd [num_tests];
  int n_loaded;
  int cycle_count;

  pmtrdt_top pmtrdt_top_inst (
    .clk          (clk),
    .rst          (rst),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .uop_ready    (uop_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

  initial begin
    clk = 1'b0;
    forever #clk_half clk = ~clk;
  end

  // element 0 lands in the low bits
  function automatic logic [pmtrdt_pkg::vlen-1:0] vec8(
    input pmtrdt_pkg::elem_t e0, input pmtrdt_pkg::elem_t e1,
    input pmtrdt_pkg::elem_t e2, input pmtrdt_pkg::elem_t e3,
    input pmtrdt_pkg::elem_t e4, input pmtrdt_pkg::elem_t e5,
    input pmtrdt_pkg::elem_t e6, input pmtrdt_pkg::elem_t e7
  );
    return {e7, e6, e5, e4, e3, e2, e1, e0};
  endfunction

  // scalar in element 0 with the rest zero
  function automatic logic [pmtrdt_pkg::vlen-1:0] lane0(input pmtrdt_pkg::elem_t e);
    return {{(pmtrdt_pkg::vlen - pmtrdt_pkg::elem_w){1'b0}}, e};
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic mismatch_error(input string name, input string field,
                                input logic [res_w-1:0] exp, input logic [res_w-1:0] act);
    $display("[ERROR] %s %s expected %h actual %h", name, field, exp, act);
    abort_run();
  endtask

  task automatic general_error(input string what);
    $display("[ERROR] %s", what);
    abort_run();
  endtask

  task automatic add_test(
    input string name,
    input pmtrdt_pkg::pmtrdt_op_e op,
    input logic [pmtrdt_pkg::num_elem-1:0] mask,
    input logic [pmtrdt_pkg::vlen-1:0] vs1,
    input logic [pmtrdt_pkg::vlen-1:0] vs2,
    input logic [pmtrdt_pkg::vlen-1:0] vd
  );
    test_name[n_loaded] = name;
    test_uop[n_loaded].op = op;
    test_uop[n_loaded].tag = pmtrdt_pkg::tag_w'(n_loaded);
    test_uop[n_loaded].mask = mask;
    test_uop[n_loaded].vs1 = vs1;
    test_uop[n_loaded].vs2 = vs2;
    test_vd[n_loaded] = vd;
    n_loaded++;
  endtask

  // reductions and compares interleaved with permutations and hand-worked vd
  task automatic load_table();
    logic [pmtrdt_pkg::vlen-1:0] seq;
    logic [pmtrdt_pkg::vlen-1:0] pat;
    logic [pmtrdt_pkg::vlen-1:0] sgn;
    logic [pmtrdt_pkg::vlen-1:0] lgc;
    logic [pmtrdt_pkg::vlen-1:0] onehot;
    logic [pmtrdt_pkg::vlen-1:0] eq_b;
    logic [pmtrdt_pkg::vlen-1:0] lt_a;
    logic [pmtrdt_pkg::vlen-1:0] lt_b;
    logic [pmtrdt_pkg::vlen-1:0] off3;
    logic [pmtrdt_pkg::vlen-1:0] zeros;
    seq = vec8(16'd1, 16'd2, 16'd3, 16'd4, 16'd5, 16'd6, 16'd7, 16'd8);
    pat = vec8(16'h11, 16'h22, 16'h33, 16'h44, 16'h55, 16'h66, 16'h77, 16'h88);
    // mix of negative, positive and extreme values
    sgn = vec8(16'hfff0, 16'h0005, 16'h8000, 16'h0010,
               16'h7fff, 16'hfffe, 16'h0003, 16'h0020);
    lgc = vec8(16'hfff0, 16'h0ff0, 16'h00ff, 16'hffff,
               16'h0000, 16'hf0f0, 16'h1234, 16'hffff);
    onehot = vec8(16'h1, 16'h2, 16'h4, 16'h8, 16'h10, 16'h20, 16'h40, 16'h80);
    eq_b = vec8(16'd1, 16'd0, 16'd3, 16'd0, 16'd5, 16'd0, 16'd7, 16'd8);
    lt_a = vec8(16'hffff, 16'h0001, 16'h8000, 16'h0005,
                16'h7fff, 16'hfff0, 16'h0000, 16'h0002);
    lt_b = vec8(16'h0000, 16'h0001, 16'h0000, 16'h0004,
                16'h8000, 16'hfff1, 16'h0001, 16'h0003);
    // only element 0 is the offset
    off3 = vec8(16'd3, 16'd1, 16'd7, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0);
    zeros = '0;
    // 100 + 1 + 3 + 5 + 7
    add_test("rdt_sum", pmtrdt_pkg::rdt_sum, 8'b0101_0101,
             lane0(16'd100), seq, lane0(16'h0074));
    add_test("slideup_0", pmtrdt_pkg::pmt_slideup, 8'h00, zeros, pat, pat);
    // signed max picks 0020 where unsigned would pick fffe
    add_test("rdt_max", pmtrdt_pkg::rdt_max, 8'b1010_1101,
             lane0(16'hff00), sgn, lane0(16'h0020));
    add_test("slideup_3", pmtrdt_pkg::pmt_slideup, 8'h5a, off3, pat,
             vec8(16'h0, 16'h0, 16'h0, 16'h11, 16'h22, 16'h33, 16'h44, 16'h55));
    add_test("rdt_min", pmtrdt_pkg::rdt_min, 8'b1010_1101,
             lane0(16'hff00), sgn, lane0(16'h8000));
    add_test("slideup_9", pmtrdt_pkg::pmt_slideup, 8'hff, lane0(16'd9), pat, zeros);
    // inactive zero element must not clear the result
    add_test("rdt_and", pmtrdt_pkg::rdt_and, 8'b1000_1011,
             lane0(16'hff3c), lgc, lane0(16'h0f30));
    add_test("slidedown_3", pmtrdt_pkg::pmt_slidedown, 8'h00, off3, pat,
             vec8(16'h44, 16'h55, 16'h66, 16'h77, 16'h88, 16'h0, 16'h0, 16'h0));
    add_test("rdt_or", pmtrdt_pkg::rdt_or, 8'b0100_0100,
             lane0(16'h0100), lgc, lane0(16'h13ff));
    add_test("slidedown_8", pmtrdt_pkg::pmt_slidedown, 8'hff, lane0(16'd8), pat, zeros);
    add_test("rdt_xor", pmtrdt_pkg::rdt_xor, 8'b1111_0000,
             lane0(16'h0f0f), onehot, lane0(16'h0fff));
    // indices 8, 0x100 and 0xffff out of range
    add_test("gather", pmtrdt_pkg::pmt_gather, 8'h00,
             vec8(16'd7, 16'd0, 16'd8, 16'd3, 16'h0100, 16'd5, 16'hffff, 16'd1), pat,
             vec8(16'h88, 16'h11, 16'h0, 16'h44, 16'h0, 16'h66, 16'h0, 16'h22));
    // raw eq mask d5 with element 7 inactive
    add_test("cmp_eq", pmtrdt_pkg::cmp_eq, 8'h7f, eq_b, seq, lane0(16'h0055));
    add_test("compress_all", pmtrdt_pkg::pmt_compress, 8'hff, zeros, pat, pat);
    // raw signed lt mask e5 with element 2 inactive
    add_test("cmp_lt", pmtrdt_pkg::cmp_lt, 8'b1111_1011, lt_b, lt_a, lane0(16'h00e1));
    add_test("compress_sparse", pmtrdt_pkg::pmt_compress, 8'b1010_0110, zeros, pat,
             vec8(16'h22, 16'h33, 16'h66, 16'h88, 16'h0, 16'h0, 16'h0, 16'h0));
    add_test("cmp_ltu", pmtrdt_pkg::cmp_ltu, 8'hff, lt_b, lt_a, lane0(16'h00f0));
    add_test("compress_none", pmtrdt_pkg::pmt_compress, 8'h00, zeros, pat, zeros);
  endtask

  task automatic send_uops();
    for (int i = 0; i < num_tests; i++) begin
      // occasional idle cycle on the input
      if ($urandom_range(3) == 0) begin
        @(posedge clk);
        uop_valid <= 1'b0;
      end
      @(posedge clk);
      uop_valid <= 1'b1;
      uop <= test_uop[i];
      // ready seen high here means the transfer is on the next edge
      @(negedge clk);
      while (!uop_ready) begin
        @(negedge clk);
      end
    end
    @(posedge clk);
    uop_valid <= 1'b0;
  endtask

  task automatic check_result(input int idx);
    assert (result.tag === pmtrdt_pkg::tag_w'(idx))
      else mismatch_error(test_name[idx], "tag", res_w'(pmtrdt_pkg::tag_w'(idx)),
                          res_w'(result.tag));
    assert (result.vd === test_vd[idx])
      else mismatch_error(test_name[idx], "vd", res_w'(test_vd[idx]), res_w'(result.vd));
  endtask

  task automatic collect_results();
    pmtrdt_pkg::pmtrdt_res_t held;
    logic holding;
    int n;
    held = '0;
    holding = 1'b0;
    n = 0;
    while (n < num_tests) begin
      @(posedge clk);
      result_ready <= ($urandom_range(3) != 0);
      @(negedge clk);
      // a refused result stays valid and unchanged
      if (holding) begin
        assert (result_valid === 1'b1)
          else general_error("result_valid dropped before the result was taken");
        assert (result === held)
          else mismatch_error(test_name[n], "held result", held, result);
      end
      if (result_valid) begin
        if (result_ready) begin
          check_result(n);
          n++;
          holding = 1'b0;
        end else begin
          holding = 1'b1;
          held = result;
        end
      end
    end
  endtask

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    general_error("timeout, results stopped arriving");
  end

  initial begin : main
    void'($urandom(seed));
    rst = 1'b1;
    uop_valid = 1'b0;
    uop = '0;
    result_ready = 1'b0;
    n_loaded = 0;
    load_table();
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    // idle state straight out of reset
    assert (uop_ready === 1'b1) else general_error("uop_ready is low after reset");
    assert (result_valid === 1'b0) else general_error("result_valid is high after reset");
    fork
      send_uops();
      collect_results();
    join
    @(posedge clk);
    result_ready <= 1'b1;
    // every tag arrived once so nothing else may show up
    repeat (2 * pmtrdt_pkg::pipe_stages + 4) begin
      @(negedge clk);
      assert (result_valid === 1'b0)
        else general_error("extra result after the last table entry");
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
rtl/pmtrdt_pkg.sv
rtl/pmtrdt_uop_queue.sv
rtl/pmtrdt_rdt_cmp.sv
rtl/pmtrdt_pmt.sv
rtl/pmtrdt_result_merge.sv
rtl/pmtrdt_top.sv
dv/pmtrdt_tb.sv

//--- Makefile
# Verilator lint, simulation and clean for the pmtrdt lane

VERILATOR ?= verilator
TOP ?= pmtrdt_tb
SEED ?= 42
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT ?= >>> PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# pass only when the pass line shows up in the simulator output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
